// ==== hw/mem_exer_params.svh ====
`ifndef MEM_EXER_PARAMS_SVH
`define MEM_EXER_PARAMS_SVH

// Line port widths
`define LINE_W 256
`define ADDR_W 28

// Pattern table
`define PAT_DEPTH 9
`define PAT_IDX_W 4

// Idle cycles between commands, and RAM response latency
`define GAP_DEFAULT 50
`define LAT_DEFAULT 4

// RAM indexed by address bits 6 to 3
`define RAM_IDX_W 4

`endif

// ==== hw/mem_exer_pkg.sv ====
`default_nettype none

`include "mem_exer_params.svh"

package mem_exer_pkg;

	typedef logic [`LINE_W-1:0] line_t;
	typedef logic [`ADDR_W-1:0] mem_addr_t;
	typedef logic [`PAT_IDX_W-1:0] pat_idx_t;

	// One command on the line port, 286 bits
	typedef struct packed {
		logic      valid;
		logic      write;
		mem_addr_t addr;
		line_t     wdata;
	} mem_cmd_t;

	// Generator sequencing
	typedef enum logic [1:0] {
		RESET_HOLD,
		ISSUE,
		WAIT_GAP
	} gen_state_e;

endpackage

`default_nettype wire

// ==== hw/pattern_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_exer_params.svh"

module pattern_rom (
	input  wire mem_exer_pkg::pat_idx_t  idx,
	output mem_exer_pkg::line_t          data,
	output mem_exer_pkg::mem_addr_t      addr
);

	import mem_exer_pkg::*;

	////////////////////////////////////////////////////////////
	// Line patterns, one per table entry
	////////////////////////////////////////////////////////////
	localparam line_t PATTERN [`PAT_DEPTH] = '{
		256'h800020C0800020C8000020D0000020D8990010E0000010E8800010F0800010F8,
		256'hFF0020C0800020C8000020D0000020DDD00010E0000010E8800010F0800010F8,
		256'h100040C0100040C8900040D0900040D8440030E0900030E8100030F0100030F8,
		256'h660040C0100040C8900040D0900040D8980030E0900030E8100030F0100030F8,
		256'hA00060D0200060F8200060D0A00060D8660050E0A00050E8A00050F0200050FF,
		256'h110060C0200060C8200060D0A00060D8200050E0A00050E8A00050F0200050F8,
		256'h300080C0B00080C8B00080D0300080D8DD0070E0300070E8300070F0B00070F8,
		256'h330080C0B00080C8B00080D0300080D8B00070E0300070E8300070F0B00070F8,
		256'h11111111000000001111111100000000FF111111000000001111111100000000
	};

	// Bits 6 to 3 step 0 to 8 so each entry lands on its own RAM line
	localparam mem_addr_t LINE_ADDR [`PAT_DEPTH] = '{
		28'h200_0000,
		28'h200_0008,
		28'h200_0010,
		28'h200_0018,
		28'h200_0020,
		28'h200_1028,
		28'h200_1030,
		28'h300_1038,
		28'h300_1040
	};

	always_comb
	begin
		data = '0;
		addr = '0;
		if (idx < pat_idx_t'(`PAT_DEPTH))
		begin
			data = PATTERN[idx];
			addr = LINE_ADDR[idx];
		end
	end

endmodule

`default_nettype wire

// ==== hw/traffic_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_exer_params.svh"

module traffic_gen #(
	parameter int GAP_CYCLES = `GAP_DEFAULT
) (
	input  wire                       clk,
	input  wire                       rst,
	output mem_exer_pkg::mem_cmd_t    cmd,
	input  wire mem_exer_pkg::line_t  rdata,
	input  wire                       ready,
	output logic                      error,
	output logic [15:0]               sweep_count
);

	import mem_exer_pkg::*;

	localparam int GAP_W = $clog2(GAP_CYCLES + 1);
	localparam pat_idx_t LAST_IDX = pat_idx_t'(`PAT_DEPTH - 1);

	gen_state_e       state;
	pat_idx_t         idx;
	logic             write_phase;
	logic [GAP_W-1:0] gap_cnt;

	line_t     pat_data;
	mem_addr_t pat_addr;

	pattern_rom u_rom (
		.idx  (idx),
		.data (pat_data),
		.addr (pat_addr)
	);

	// Command fields only move during the gap, so they hold until ready
	always_comb
	begin
		cmd.valid = (state == ISSUE);
		cmd.write = write_phase;
		cmd.addr  = pat_addr;
		cmd.wdata = pat_data;
	end

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state       <= RESET_HOLD;
			idx         <= '0;
			write_phase <= 1'b1;
			gap_cnt     <= '0;
			sweep_count <= '0;
		end
		else
		begin
			unique case (state)
				RESET_HOLD:
				begin
					state <= ISSUE;
				end
				ISSUE:
				begin
					if (ready)
					begin
						state   <= WAIT_GAP;
						gap_cnt <= '0;
						// Last entry wraps and flips write/read
						if (idx == LAST_IDX)
						begin
							idx         <= '0;
							write_phase <= ~write_phase;
							if (!write_phase)
							begin
								sweep_count <= sweep_count + 16'd1;
							end
						end
						else
						begin
							idx <= idx + pat_idx_t'(1);
						end
					end
				end
				WAIT_GAP:
				begin
					if (gap_cnt == GAP_W'(GAP_CYCLES - 1))
					begin
						state <= ISSUE;
					end
					else
					begin
						gap_cnt <= gap_cnt + GAP_W'(1);
					end
				end
				default:
				begin
					state <= RESET_HOLD;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Read-back checker
	////////////////////////////////////////////////////////////
	// Sticky until the next reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			error <= 1'b0;
		end
		else if (ready && cmd.valid && !cmd.write && (rdata != pat_data))
		begin
			error <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/line_ram_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_exer_params.svh"

module line_ram_port #(
	parameter int LATENCY = `LAT_DEFAULT
) (
	input  wire                           clk,
	input  wire                           rst,
	input  wire mem_exer_pkg::mem_cmd_t   cmd,
	input  wire                           fault_inject,
	output mem_exer_pkg::line_t           rdata,
	output logic                          ready
);

	import mem_exer_pkg::*;

	localparam int CNT_W = $clog2(LATENCY + 1);

	line_t mem [2**`RAM_IDX_W];

	logic [`RAM_IDX_W-1:0] ram_idx;
	line_t                 wline;

	logic [CNT_W-1:0] lat_cnt;
	logic             busy;
	logic             done;

	// Line select from address bits 6 to 3
	assign ram_idx = cmd.addr[3 +: `RAM_IDX_W];

	// Fault injection flips bit 0 of the stored line
	assign wline = cmd.wdata ^ {{(`LINE_W-1){1'b0}}, fault_inject};

	assign ready = busy && (lat_cnt == CNT_W'(LATENCY));
	assign rdata = mem[ram_idx];

	////////////////////////////////////////////////////////////
	// Latency counter
	////////////////////////////////////////////////////////////
	// busy counts from the first valid cycle, done waits for valid to drop
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy    <= 1'b0;
			done    <= 1'b0;
			lat_cnt <= '0;
		end
		else if (ready)
		begin
			busy    <= 1'b0;
			done    <= 1'b1;
			lat_cnt <= '0;
		end
		else if (busy)
		begin
			lat_cnt <= lat_cnt + CNT_W'(1);
		end
		else if (done)
		begin
			if (!cmd.valid)
			begin
				done <= 1'b0;
			end
		end
		else if (cmd.valid)
		begin
			busy    <= 1'b1;
			lat_cnt <= CNT_W'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (ready && cmd.write)
		begin
			mem[ram_idx] <= wline;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_exer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_exer_params.svh"

module mem_exer_top (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       fault_inject,
	output logic                      error,
	output logic [15:0]               sweep_count,
	output mem_exer_pkg::mem_cmd_t    mon_cmd,
	output mem_exer_pkg::line_t       mon_rdata,
	output logic                      mon_ready
);

	import mem_exer_pkg::*;

	// Line port between generator and RAM
	mem_cmd_t cmd;
	line_t    rdata;
	logic     ready;

	traffic_gen #(
		.GAP_CYCLES (`GAP_DEFAULT)
	) u_gen (
		.clk         (clk),
		.rst         (rst),
		.cmd         (cmd),
		.rdata       (rdata),
		.ready       (ready),
		.error       (error),
		.sweep_count (sweep_count)
	);

	line_ram_port #(
		.LATENCY (`LAT_DEFAULT)
	) u_ram (
		.clk          (clk),
		.rst          (rst),
		.cmd          (cmd),
		.fault_inject (fault_inject),
		.rdata        (rdata),
		.ready        (ready)
	);

	// Monitor taps on the internal port
	assign mon_cmd   = cmd;
	assign mon_rdata = rdata;
	assign mon_ready = ready;

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	input  wire  rst_req,
	output logic clk,
	output logic rst
);

	logic por;

	// 100 ns period
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#50 clk = ~clk;
		end
	end

	// Power-on reset for 8 cycles, released just after an edge
	initial
	begin
		por = 1'b1;
		repeat (8) @(posedge clk);
		#1 por = 1'b0;
	end

	assign rst = por | rst_req;

endmodule

`default_nettype wire

// ==== dv/mem_exer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_exer_params.svh"

module mem_exer_tb;

	import mem_exer_pkg::*;

	localparam int LAT   = `LAT_DEFAULT;
	localparam int GAP   = `GAP_DEFAULT;
	localparam int DEPTH = `PAT_DEPTH;

	logic        clk;
	logic        rst;
	logic        rst_req;
	logic        fault_inject;
	logic        error;
	logic [15:0] sweep_count;
	mem_cmd_t    mon_cmd;
	line_t       mon_rdata;
	logic        mon_ready;

	// Lines seen on the write sweep, reference for the read-back
	mem_addr_t wr_addr [DEPTH];
	line_t     wr_data [DEPTH];

	int seed;
	int checks;
	int errors;
	int timeouts;

	tb_clk_gen u_clk (
		.rst_req (rst_req),
		.clk     (clk),
		.rst     (rst)
	);

	mem_exer_top uut (
		.clk          (clk),
		.rst          (rst),
		.fault_inject (fault_inject),
		.error        (error),
		.sweep_count  (sweep_count),
		.mon_cmd      (mon_cmd),
		.mon_rdata    (mon_rdata),
		.mon_ready    (mon_ready)
	);

	task automatic compare_values(input logic [511:0] got, input logic [511:0] exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		timeouts++;
		$display("Timeout at %0t ns: gave up waiting for %s", $time, what);
	endtask

	task automatic expect_idle();
		compare_values(mon_cmd.valid, 1'b0, "valid inactive");
		compare_values(mon_ready, 1'b0, "ready inactive");
		compare_values(error, 1'b0, "error inactive");
		compare_values(sweep_count, 16'd0, "sweep count zero");
	endtask

	// Entered at the first negedge with rst low
	task automatic check_release();
		expect_idle();
		@(negedge clk);
		compare_values(mon_cmd.valid, 1'b1, "valid rises after reset");
		compare_values(mon_cmd.write, 1'b1, "first command is a write");
		compare_values(mon_cmd.addr[6:3], 4'd0, "first command is entry 0");
	endtask

	// Entered at the first negedge of a command, leaves at the first negedge of the next
	task automatic run_command(input bit inject, output mem_cmd_t c, output line_t rd);
		int lat;
		int gap;
		c = mon_cmd;
		rd = '0;
		compare_values(c.valid, 1'b1, "valid at command start");
		if (inject)
		begin
			@(posedge clk);
			#1 fault_inject = 1'b1;
		end
		lat = 0;
		while (!mon_ready && lat < LAT + 10)
		begin
			@(negedge clk);
			lat++;
			compare_values(mon_cmd, c, "command held until ready");
		end
		if (!mon_ready)
		begin
			note_timeout("the ready pulse");
			return;
		end
		compare_values(lat, LAT, "ready latency");
		rd = mon_rdata;
		if (inject)
		begin
			@(posedge clk);
			#1 fault_inject = 1'b0;
		end
		gap = 0;
		@(negedge clk);
		while (!mon_cmd.valid && gap < GAP + 10)
		begin
			compare_values(mon_ready, 1'b0, "ready low in gap");
			gap++;
			@(negedge clk);
		end
		if (!mon_cmd.valid)
			note_timeout("valid of the next command");
		else
			compare_values(gap, GAP, "idle gap length");
	endtask

	task automatic reset_state();
		int n;
		n = 0;
		@(negedge clk);
		while (rst && n < 40)
		begin
			expect_idle();
			n++;
			@(negedge clk);
		end
		if (rst)
			note_timeout("reset release");
		else
			check_release();
	endtask

	task automatic write_sweep(input int inject_idx);
		mem_cmd_t c;
		line_t    rd;
		for (int i = 0; i < DEPTH; i++)
		begin
			run_command(i == inject_idx, c, rd);
			compare_values(c.write, 1'b1, "command is a write");
			compare_values(c.addr[6:3], i, "address bits 6 to 3 follow the entry");
			if (i > 0)
				compare_values(c.addr > wr_addr[i-1], 1'b1, "addresses rise strictly");
			wr_addr[i] = c.addr;
			wr_data[i] = c.wdata;
		end
	endtask

	task automatic read_back(input int fault_idx, input bit err_before, input int sweeps);
		mem_cmd_t c;
		line_t    rd;
		line_t    exp_rd;
		for (int i = 0; i < DEPTH; i++)
		begin
			run_command(1'b0, c, rd);
			compare_values(c.write, 1'b0, "command is a read");
			compare_values(c.addr, wr_addr[i], "read address follows write order");
			exp_rd = wr_data[i];
			if (i == fault_idx)
				exp_rd[0] = ~exp_rd[0];
			compare_values(rd, exp_rd, "read data");
			compare_values(error, err_before || (fault_idx >= 0 && i >= fault_idx),
				"error flag");
		end
		compare_values(sweep_count, sweeps, "sweep count after read sweep");
		compare_values(mon_cmd.write, 1'b1, "next command is a write");
		compare_values(mon_cmd.addr, wr_addr[0], "next command is entry 0");
	endtask

	task automatic fault_detection();
		int pick;
		pick = ($random(seed) & 32'h7fff_ffff) % DEPTH;
		$display("Injecting a fault on entry %0d", pick);
		write_sweep(pick);
		read_back(pick, 1'b0, 2);
	endtask

	// A clean sweep rewrites the bad line but the flag stays set
	task automatic error_sticky();
		write_sweep(-1);
		read_back(-1, 1'b1, 3);
	endtask

	task automatic reset_clears_error();
		compare_values(error, 1'b1, "error still set before reset");
		@(posedge clk);
		#1 rst_req = 1'b1;
		repeat (7)
		begin
			@(posedge clk);
			@(negedge clk);
			expect_idle();
		end
		@(posedge clk);
		#1 rst_req = 1'b0;
		@(negedge clk);
		check_release();
	endtask

	initial
	begin
		rst_req = 1'b0;
		fault_inject = 1'b0;
		seed = 32'hb77f8f4e;
		checks = 0;
		errors = 0;
		timeouts = 0;
		reset_state();
		write_sweep(-1);
		read_back(-1, 1'b0, 1);
		fault_detection();
		error_sticky();
		reset_clears_error();
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/mem_exer_pkg.sv
hw/pattern_rom.sv
hw/traffic_gen.sv
hw/line_ram_port.sv
hw/mem_exer_top.sv
dv/tb_clk_gen.sv
dv/mem_exer_tb.sv

// ==== Bender.yml ====
package:
  name: mem_exer

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_exer_pkg.sv
      - hw/pattern_rom.sv
      - hw/traffic_gen.sv
      - hw/line_ram_port.sv
      - hw/mem_exer_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_clk_gen.sv
      - dv/mem_exer_tb.sv
